// File: rtl/aes_pkg.sv
// shared types and constants for the AES-128 encryption datapath
// only 128-bit keys and the forward cipher are covered
package aes_pkg;

  // one 128-bit block, used for plaintext, round state and ciphertext
  typedef logic [127:0] aes_block_t;

  // one 128-bit round key
  typedef logic [127:0] aes_key_t;

  // one byte through the S-box
  typedef logic [7:0] aes_byte_t;

  // round counter, holds 0 to 10
  typedef logic [3:0] aes_round_t;

  // AES-128 always runs ten rounds
  localparam aes_round_t AES_ROUNDS = 4'd10;

  // core sequencing states
  typedef enum logic [1:0] {
    core_idle,
    core_run,
    core_done
  } aes_core_state_t;

  // multiply by x in GF(2^8) with the AES reduction polynomial
  // shared by MixColumns and the round constant sequence
  function automatic aes_byte_t aes_xtime(input aes_byte_t b);
    aes_byte_t shifted;
    shifted = {b[6:0], 1'b0};
    return b[7] ? (shifted ^ 8'h1b) : shifted;
  endfunction

endpackage

// File: rtl/aes_sbox.sv
// forward AES S-box for one byte, purely combinational
// no inverse table, so this cannot serve a decryptor
`timescale 1ns/10ps

module aes_sbox
  import aes_pkg::*;
(
  input  aes_byte_t in_byte,
  output aes_byte_t out_byte
);

  // FIPS-197 forward substitution table, indexed by the input byte
  // each line covers eight consecutive input values, two lines per high nibble
  localparam aes_byte_t SBOX_TABLE [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // a plain table read, which synthesis maps to LUTs or a ROM
  assign out_byte = SBOX_TABLE[in_byte];

endmodule

// File: rtl/aes_key_expand.sv
// one step of the AES-128 key schedule, combinational
// round must be 1 to 10, round 0 gives the rcon of round 1
`timescale 1ns/10ps

module aes_key_expand
  import aes_pkg::*;
(
  input  aes_key_t   round_key,
  input  aes_round_t round,
  output aes_key_t   next_key
);

  aes_byte_t   rcon;
  logic [31:0] rot_word;
  logic [31:0] sub_word;
  logic [31:0] w0;
  logic [31:0] w1;
  logic [31:0] w2;
  logic [31:0] w3;

  // the round constant starts at 01 and doubles once per round,
  // so rounds 9 and 10 wrap through the reduction to 1b and 36
  always_comb begin
    rcon = 8'h01;
    for (int i = 1; i < int'(AES_ROUNDS); i++) begin
      if (i < int'(round)) begin
        rcon = aes_xtime(rcon);
      end
    end
  end

  // RotWord on the last word of the current key
  assign rot_word = {round_key[23:0], round_key[31:24]};

  // SubWord, one S-box per byte of the rotated word
  for (genvar i = 0; i < 4; i++) begin : g_sub_word
    aes_sbox sbox_i (
      .in_byte  (rot_word[31-8*i -: 8]),
      .out_byte (sub_word[31-8*i -: 8])
    );
  end

  // each new word chains off the previous new word
  assign w0 = round_key[127:96] ^ sub_word ^ {rcon, 24'h000000};
  assign w1 = round_key[95:64] ^ w0;
  assign w2 = round_key[63:32] ^ w1;
  assign w3 = round_key[31:0] ^ w2;

  assign next_key = {w0, w1, w2, w3};

endmodule

// File: rtl/aes_round.sv
// one complete AES encryption round, combinational
// state bytes are column-major as in FIPS-197, byte 0 in bits 127:120
`timescale 1ns/10ps

module aes_round
  import aes_pkg::*;
(
  input  aes_block_t state,
  input  aes_key_t   round_key,
  input  logic       last_round,
  output aes_block_t next_state
);

  aes_block_t sub_bytes;
  aes_block_t shift_rows;
  aes_block_t mix_cols;

  // MixColumns on one 32-bit column, top byte is row 0
  function automatic logic [31:0] mix_column(input logic [31:0] col);
    aes_byte_t a0;
    aes_byte_t a1;
    aes_byte_t a2;
    aes_byte_t a3;
    aes_byte_t b0;
    aes_byte_t b1;
    aes_byte_t b2;
    aes_byte_t b3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    // multiply by 3 is xtime plus the byte itself
    b0 = aes_xtime(a0) ^ aes_xtime(a1) ^ a1 ^ a2 ^ a3;
    b1 = a0 ^ aes_xtime(a1) ^ aes_xtime(a2) ^ a2 ^ a3;
    b2 = a0 ^ a1 ^ aes_xtime(a2) ^ aes_xtime(a3) ^ a3;
    b3 = aes_xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_xtime(a3);
    return {b0, b1, b2, b3};
  endfunction

  // SubBytes, sixteen S-boxes side by side
  for (genvar i = 0; i < 16; i++) begin : g_sub_bytes
    aes_sbox sbox_i (
      .in_byte  (state[127-8*i -: 8]),
      .out_byte (sub_bytes[127-8*i -: 8])
    );
  end

  // ShiftRows rotates row r left by r positions
  // byte index is 4*column + row
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shift_rows[127-8*(4*c+r) -: 8] = sub_bytes[127-8*(4*((c+r)%4)+r) -: 8];
      end
    end
  end

  // MixColumns works on each column on its own
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      mix_cols[127-32*c -: 32] = mix_column(shift_rows[127-32*c -: 32]);
    end
  end

  // the final round has no MixColumns, AddRoundKey closes every round
  assign next_state = (last_round ? shift_rows : mix_cols) ^ round_key;

endmodule

// File: rtl/aes_core.sv
// iterative AES-128 encryptor, one round per sclk edge
// starts on the first edge that sees load low after it was high
// done stays up until load is sampled high again, key and plaintext must hold meanwhile
`timescale 1ns/10ps

module aes_core
  import aes_pkg::*;
(
  input  logic       sclk,
  input  logic       rst_n,
  input  logic       load,
  input  aes_key_t   key,
  input  aes_block_t plaintext,
  output aes_block_t cyphertext,
  output logic       done
);

  aes_core_state_t fsm_state;
  aes_block_t      state_reg;
  aes_block_t      round_out;
  aes_key_t        key_reg;
  aes_key_t        next_key;
  aes_round_t      round_cnt;
  logic            load_q;
  logic            last_round;

  // round_cnt holds the number of the round applied on the next edge
  assign last_round = (round_cnt == AES_ROUNDS);

  aes_key_expand key_expand_i (
    .round_key (key_reg),
    .round     (round_cnt),
    .next_key  (next_key)
  );

  aes_round round_i (
    .state      (state_reg),
    .round_key  (next_key),
    .last_round (last_round),
    .next_state (round_out)
  );

  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      fsm_state <= core_idle;
      state_reg <= '0;
      key_reg   <= '0;
      round_cnt <= '0;
      load_q    <= 1'b0;
    end else begin
      load_q <= load;
      if (load) begin
        // a new block is arriving, so whatever was in flight is dropped
        fsm_state <= core_idle;
        round_cnt <= '0;
      end else begin
        case (fsm_state)
          core_idle: begin
            // falling edge of load, the initial AddRoundKey happens here
            if (load_q) begin
              state_reg <= plaintext ^ key;
              key_reg   <= key;
              round_cnt <= 4'd1;
              fsm_state <= core_run;
            end
          end
          core_run: begin
            state_reg <= round_out;
            key_reg   <= next_key;
            if (last_round) begin
              fsm_state <= core_done;
            end else begin
              round_cnt <= round_cnt + 4'd1;
            end
          end
          default: begin
            // core_done holds the result until load rises
          end
        endcase
      end
    end
  end

  assign cyphertext = state_reg;
  assign done       = (fsm_state == core_done);

  // once load has been seen high for a full cycle, done must have dropped
  a_done_clears_on_load: assert property (
    @(posedge sclk) disable iff (!rst_n) $past(load) |-> !done
  ) else $error("done still high a cycle after load was sampled high");

  a_round_in_range: assert property (
    @(posedge sclk) disable iff (!rst_n) round_cnt <= AES_ROUNDS
  ) else $error("round counter beyond the last AES round");

endmodule

// File: rtl/aes_spi.sv
// SPI side of the accelerator, no chip select, master owns sclk
// shift-in: 256 bits while load is high, plaintext MSB first then key MSB first
// readout: ct[127] is on miso at the first rising edge that sees done high, then one bit per edge
`timescale 1ns/10ps

module aes_spi
  import aes_pkg::*;
(
  input  logic       sclk,
  input  logic       rst_n,
  input  logic       mosi,
  input  logic       load,
  input  logic       done,
  input  aes_block_t cyphertext,
  output logic       miso,
  output aes_key_t   key,
  output aes_block_t plaintext
);

  aes_block_t captured;
  logic       was_done;
  logic       was_done_q;
  logic       miso_delayed;

  // mosi enters key[0] and key[127] spills into plaintext[0]
  // the copy of the ciphertext tracks the core until readout begins,
  // then shifts left one bit per edge with zeros filling in
  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      key       <= '0;
      plaintext <= '0;
      captured  <= '0;
    end else begin
      if (load) begin
        {plaintext, key} <= {plaintext[126:0], key, mosi};
      end
      if (!was_done_q) begin
        captured <= cyphertext;
      end else begin
        captured <= {captured[126:0], 1'b0};
      end
    end
  end

  // miso moves on the falling edge so the master gets half a cycle of setup
  // bit 126 of the copy is the bit due at the next rising edge, because
  // that edge shifts the copy while miso still shows the older top bit
  always_ff @(negedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      was_done     <= 1'b0;
      was_done_q   <= 1'b0;
      miso_delayed <= 1'b0;
    end else begin
      was_done     <= done;
      was_done_q   <= was_done;
      miso_delayed <= captured[126];
    end
  end

  // for the first half-to-full cycle after done is seen on a falling edge,
  // the MSB comes straight from the core while the copy is being loaded
  assign miso = (was_done && !was_done_q) ? cyphertext[127] : miso_delayed;

  // load may overlap done only in the half cycle before the core sees load
  a_load_done_exclusive: assert property (
    @(negedge sclk) disable iff (!rst_n) $past(load) |-> !done
  ) else $error("load and done both high across a falling edge");

endmodule

// File: rtl/aes_top.sv
// AES-128 encryption accelerator behind a bit-serial SPI link
// one ECB block at a time, sclk must keep running while the core encrypts
`timescale 1ns/10ps

module aes_top
  import aes_pkg::*;
(
  input  logic sclk,
  input  logic rst_n,
  input  logic load,
  input  logic mosi,
  output logic miso,
  output logic done
);

  aes_key_t   key;
  aes_block_t plaintext;
  aes_block_t cyphertext;

  // serial capture of key and plaintext, serial readout of the result
  aes_spi spi_i (
    .sclk       (sclk),
    .rst_n      (rst_n),
    .mosi       (mosi),
    .load       (load),
    .done       (done),
    .cyphertext (cyphertext),
    .miso       (miso),
    .key        (key),
    .plaintext  (plaintext)
  );

  // round engine, eleven edges from the fall of load to done
  aes_core core_i (
    .sclk       (sclk),
    .rst_n      (rst_n),
    .load       (load),
    .key        (key),
    .plaintext  (plaintext),
    .cyphertext (cyphertext),
    .done       (done)
  );

endmodule

// File: testbench/tb_clock_gen.sv
// free-running sclk with a 100 ns period and a power-on reset
// rst_n stays low for the first 16 rising edges and is released on a falling edge
`timescale 1ns/10ps

module tb_clock_gen (
  output logic sclk,
  output logic rst_n
);

  initial begin
    sclk = 1'b0;
    forever begin
      #50 sclk = ~sclk;
    end
  end

  // the release lands half a cycle away from any sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge sclk);
    @(negedge sclk);
    rst_n = 1'b1;
  end

endmodule

// File: testbench/tb_aes_top.sv
// drives aes_top over SPI from the vectors in testbench/aes_trace.txt
// must be run from the project root so that the trace path resolves
`timescale 1ns/10ps

module tb_aes_top;

  localparam int TRACE_WORDS  = 64;
  localparam int DONE_TIMEOUT = 50;
  localparam int LATENCY      = 11;

  logic sclk;
  logic rst_n;
  logic load;
  logic mosi;
  logic miso;
  logic done;

  // one trace row is four words: action, key, plaintext, expected ciphertext
  logic [127:0] trace_mem [0:TRACE_WORDS-1];

  // outputs as seen 5 ns before the coming rising edge
  logic done_s;
  logic miso_s;
  int   errors;
  int   timeouts;

  tb_clock_gen clock_gen_i (
    .sclk  (sclk),
    .rst_n (rst_n)
  );

  aes_top aes_top_i (
    .sclk  (sclk),
    .rst_n (rst_n),
    .load  (load),
    .mosi  (mosi),
    .miso  (miso),
    .done  (done)
  );

  task automatic check_value(input logic [127:0] expected, input logic [127:0] actual,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0d ns: %s, expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  // samples the outputs late in the low phase, then drives the inputs on the rising edge
  // the DUT sees the new inputs only on the following rising edge
  task automatic run_edge(input logic load_v, input logic mosi_v);
    @(negedge sclk);
    #45;
    done_s = done;
    miso_s = miso;
    @(posedge sclk);
    load <= load_v;
    mosi <= mosi_v;
  endtask

  // sends count bits from the top of bits with load high, then drops load
  task automatic shift_block(input logic [255:0] bits, input int count, input logic done_before);
    logic [255:0] tx;
    tx = bits;
    for (int i = 0; i < count; i++) begin
      run_edge(1'b1, tx[255]);
      tx = {tx[254:0], 1'b0};
      // done only drops once the core has sampled load high, two samples in
      if (i < 2) begin
        check_value(128'(done_before), 128'(done_s), "done before load was sampled");
      end else begin
        check_value(128'd0, 128'(done_s), "done while shifting in");
      end
    end
    run_edge(1'b0, 1'b0);
    check_value(128'd0, 128'(done_s), "done at the end of shift-in");
  endtask

  // edges counts the calls, the first of which is the edge that samples load low
  task automatic wait_done(output int edges, output logic timed_out);
    edges = 0;
    timed_out = 1'b0;
    done_s = 1'b0;
    while (!done_s && !timed_out) begin
      run_edge(1'b0, 1'b0);
      edges++;
      if (!done_s && edges >= DONE_TIMEOUT) begin
        timed_out = 1'b1;
      end
    end
  endtask

  // the sample that first shows done already carries the ciphertext MSB
  task automatic read_cipher(input int count, output logic [127:0] got);
    got = 128'(miso_s);
    for (int j = 1; j < count; j++) begin
      run_edge(1'b0, 1'b0);
      check_value(128'd1, 128'(done_s), "done during readout");
      got = {got[126:0], miso_s};
    end
  endtask

  // idle clocks before a transfer, past a full readout miso only shifts out zeros
  task automatic idle_cycles(input int n, input logic expect_done, input logic quiet);
    for (int i = 0; i < n; i++) begin
      run_edge(1'b0, 1'b0);
      check_value(128'(expect_done), 128'(done_s), "done while idle");
      if (quiet) begin
        check_value(128'd0, 128'(miso_s), "miso while idle");
      end
    end
  endtask

  initial begin
    int           seed;
    int           gap;
    int           edges;
    int           rows;
    logic         timed_out;
    logic         prev_done;
    logic         quiet;
    logic         aborted;
    logic [5:0]   addr;
    logic [3:0]   action;
    logic [127:0] key;
    logic [127:0] pt;
    logic [127:0] ct;
    logic [127:0] got;

    load <= 1'b0;
    mosi <= 1'b0;
    errors = 0;
    timeouts = 0;
    seed = $urandom(32'h5f45);
    $readmemh("testbench/aes_trace.txt", trace_mem);

    // rst_n may still be unknown at time zero, so only a clean high ends the wait
    edges = 0;
    while (rst_n !== 1'b1 && edges < 40) begin
      @(posedge sclk);
      edges++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was never released, no tests were run");
      timeouts++;
    end

    // right after reset both outputs must be quiet
    run_edge(1'b0, 1'b0);
    check_value(128'd0, 128'(done_s), "done after reset");
    check_value(128'd0, 128'(miso_s), "miso after reset");

    addr = '0;
    rows = 0;
    prev_done = 1'b0;
    quiet = 1'b1;
    aborted = 1'b0;
    action = trace_mem[addr][3:0];
    while (timeouts == 0 && action != 4'd0 && rows < TRACE_WORDS / 4) begin
      key = trace_mem[addr + 6'd1];
      pt = trace_mem[addr + 6'd2];
      ct = trace_mem[addr + 6'd3];
      if (action > 4'd3) begin
        $display("trace row %0d has an unknown action code %0d", rows, action);
        errors++;
      end else begin
        // an abort goes straight into the next load, in the middle of the readout
        if (!aborted) begin
          gap = int'($urandom % 32'd21);
          idle_cycles(gap, prev_done, quiet);
        end
        // a short row shifts only the plaintext half, pushing the old key up
        if (action == 4'd3) begin
          shift_block({pt, key}, 128, prev_done);
        end else begin
          shift_block({pt, key}, 256, prev_done);
        end
        wait_done(edges, timed_out);
        if (timed_out) begin
          $display("done did not rise within %0d cycles on trace row %0d", DONE_TIMEOUT, rows);
          timeouts++;
        end else begin
          check_value(128'(LATENCY), 128'(edges - 1), "edges from load low to done");
          if (action == 4'd2) begin
            read_cipher(40, got);
            check_value(128'(ct[127:88]), 128'(got[39:0]), "first 40 ciphertext bits");
          end else begin
            read_cipher(128, got);
            check_value(ct, got, "ciphertext");
          end
        end
        prev_done = 1'b1;
        quiet = (action != 4'd2);
        aborted = (action == 4'd2);
      end
      rows++;
      addr = addr + 6'd4;
      action = trace_mem[addr][3:0];
    end

    if (rows == 0) begin
      $display("the trace file held no test rows");
      errors++;
    end

    $display("closing: %0d errors, %0d timeouts, %0d trace rows", errors, timeouts, rows);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: aes_top.f
rtl/aes_pkg.sv
rtl/aes_sbox.sv
rtl/aes_key_expand.sv
rtl/aes_round.sv
rtl/aes_core.sv
rtl/aes_spi.sv
rtl/aes_top.sv
testbench/tb_clock_gen.sv
testbench/tb_aes_top.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module tb_aes_top \
  -f aes_top.f \
  -o tb_aes_top

out=$(./obj_dir/tb_aes_top)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

// File: testbench/aes_trace.txt
// columns: action key plaintext expected_ciphertext, all hex, one test per line
// action 1 normal, 2 abort after 40 readout bits, 3 short load of 128 bits, 0 ends the trace
// FIPS-197 appendix B and C.1
1 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
1 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
// all-zero key and block
1 00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
// ECB vectors under the appendix B key
1 2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
// readout abandoned after 40 bits, the next row must still come out right
2 2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
1 2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
// zero key, which stays in the key register for the short row
1 00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
// short row: the plaintext column lands in the key register, the old zero key becomes plaintext
3 00000000000000000000000000000000 10a58869d74be5a374cf867cfb473859 6d251e6944b051e04eaa6fb4dbf78465
1 caea65cdbb75e9169ecd22ebe6e54675 00000000000000000000000000000000 6e29201190152df4ee058139def610bb
1 00000000000000000000000000000000 9798c4640bad75c7c3227db910174e72 a9a1631bf4996954ebc093957b234589
1 2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
// end of trace
0 0 0 0
